// File: hw/lsu_params.svh
//////////////////////////////////////////////////////////////////////
// width defines shared by the load/store unit RTL and its testbench
// include this file wherever a data, byte-enable or offset width is needed
//////////////////////////////////////////////////////////////////////

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_DATA_W 32

// byte lanes per bus word
`define LSU_BE_W 4

// byte offset inside a word
`define LSU_OFF_W 2

`endif

// File: hw/lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// types of the load/store unit: access size and controller state enums,
// and the packed bundles exchanged with the core and the data bus
//////////////////////////////////////////////////////////////////////

`include "lsu_params.svh"

package lsu_pkg;

  // access size, both byte codes of the core fold into SIZE_BYTE
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,               // first beat of a split access not granted yet
    WAIT_RVALID_MIS,            // first beat granted, second beat pending
    WAIT_GNT,                   // single beat (or last beat) waiting for grant
    WAIT_RVALID_MIS_GNTS_DONE   // both granted, first response outstanding
  } ls_fsm_e;

  // request attributes from the core
  typedef struct packed {
    logic                   we;        // 1 = store
    lsu_size_e              size;
    logic                   sign_ext;  // sign extend byte/half loads
    logic [`LSU_DATA_W-1:0] wdata;     // store data, lsb aligned
  } lsu_req_t;

  // one outgoing bus beat
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;      // always word aligned
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;     // rotated to byte lanes
  } bus_req_t;

  // bus response
  typedef struct packed {
    logic                   rvalid;
    logic                   err;
    logic [`LSU_DATA_W-1:0] rdata;
  } bus_rsp_t;

  // response back to the core
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   rdata_valid;  // load data good
    logic                   resp_valid;   // access finished, ok or not
    logic                   load_err;
    logic                   store_err;
  } lsu_rsp_t;

endpackage

// File: hw/lsu_store_align.sv
//////////////////////////////////////////////////////////////////////
// store path of the load/store unit: byte enables for first and second
// bus beat, and store data rotated onto its byte lanes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_store_align import lsu_pkg::*; (
  input  logic [`LSU_OFF_W-1:0]  addr_off_i,     // byte offset of the access
  input  lsu_size_e              size_i,
  input  logic                   second_beat_i,  // second half of a split access
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o
);

  logic [`LSU_BE_W-1:0]     be_mask;   // lanes of the access at offset 0
  logic [2*`LSU_BE_W-1:0]   be_span;   // mask placed across two words
  logic [2*`LSU_DATA_W-1:0] wdata_dbl; // doubled word for rotation

  //////////////////////////////////////////////////////////////////////
  // byte enables

  always_comb begin
    unique case (size_i)
      SIZE_WORD: be_mask = 4'b1111;
      SIZE_HALF: be_mask = 4'b0011;
      SIZE_BYTE: be_mask = 4'b0001;
      default:   be_mask = 4'b1111;
    endcase
  end

  // shifting by the offset pushes the tail of a split access into the
  // upper nibble, which is exactly the low lanes of the next word
  always_comb begin
    be_span = {{`LSU_BE_W{1'b0}}, be_mask} << addr_off_i;
    if (second_beat_i) begin
      be_o = be_span[2*`LSU_BE_W-1:`LSU_BE_W];  // remaining low lanes
    end else begin
      be_o = be_span[`LSU_BE_W-1:0];            // offset upward
    end

    // only the unused second beat of an aligned word may be empty
    if (!(second_beat_i && size_i == SIZE_WORD && addr_off_i == '0)) begin
      a_be_nonzero: assert (be_o != '0)
        else $error("store_align: empty byte enables on an active beat");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // store data rotation

  // rotate left by offset bytes, so byte 0 lands on lane addr_off_i
  // and the bytes that wrap around serve the second beat
  assign wdata_dbl = {wdata_i, wdata_i} << {addr_off_i, 3'b000};
  assign wdata_o   = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

// File: hw/lsu_load_align.sv
//////////////////////////////////////////////////////////////////////
// load path of the load/store unit: holds the attributes of the access
// in flight and the first-beat data, then realigns and extends the load
// result from the current bus beat
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_load_align import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ctrl_update_i,   // capture attributes + offset
  input  logic                   rdata_update_i,  // capture first-beat data
  input  lsu_req_t               attr_i,
  input  logic [`LSU_OFF_W-1:0]  addr_off_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,         // data of the current beat
  output logic [`LSU_DATA_W-1:0] rdata_o,         // realigned, extended
  output logic                   we_q_o           // access in flight is a store
);

  // captured access attributes
  logic [`LSU_OFF_W-1:0]    off_q;
  lsu_size_e                size_q;
  logic                     sign_ext_q;
  logic                     we_q;

  // upper three bytes of the first beat, byte 0 never needed
  logic [`LSU_DATA_W-1:8]   rdata_q;

  logic                     split_q;   // access used two beats
  logic [`LSU_DATA_W-1:0]   low_word;  // word below the current beat
  logic [2*`LSU_DATA_W-1:0] win;       // two words shifted down by offset
  logic [`LSU_DATA_W-1:0]   rdata_w;
  logic [`LSU_DATA_W-1:0]   rdata_h;
  logic [`LSU_DATA_W-1:0]   rdata_b;

  //////////////////////////////////////////////////////////////////////
  // capture registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      off_q      <= '0;
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      off_q      <= addr_off_i;
      size_q     <= attr_i.size;
      sign_ext_q <= attr_i.sign_ext;
      we_q       <= attr_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= rdata_i[`LSU_DATA_W-1:8];  // payload only
    end
  end

  //////////////////////////////////////////////////////////////////////
  // realignment

  assign split_q = ((size_q == SIZE_WORD) && (off_q != '0)) ||
                   ((size_q == SIZE_HALF) && (off_q == '1));

  // split access: first-beat bytes sit below the current beat
  // single beat: the beat itself, bytes never wrap past lane 3
  assign low_word = split_q ? {rdata_q, 8'h00} : rdata_i;

  assign win = {rdata_i, low_word} >> {off_q, 3'b000};

  assign rdata_w = win[`LSU_DATA_W-1:0];
  assign rdata_h = {{16{sign_ext_q & win[15]}}, win[15:0]};  // zero when unsigned
  assign rdata_b = {{24{sign_ext_q & win[7]}}, win[7:0]};

  always_comb begin
    unique case (size_q)
      SIZE_WORD: rdata_o = rdata_w;
      SIZE_HALF: rdata_o = rdata_h;
      SIZE_BYTE: rdata_o = rdata_b;
      default:   rdata_o = rdata_w;
    endcase
  end

  assign we_q_o = we_q;

  //////////////////////////////////////////////////////////////////////
  // checks

  // core must hand over a legal size and a known offset with each grant
  a_size_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_update_i |=> (size_q inside {SIZE_WORD, SIZE_HALF, SIZE_BYTE}) &&
                      !$isunknown(off_q))
    else $error("load_align: captured size or offset not valid");

endmodule

// File: hw/lsu_ctrl.sv
//////////////////////////////////////////////////////////////////////
// controller of the load/store unit: sequences one or two bus beats per
// request, tracks first-beat errors, keeps the last address for traps
// and the second-beat increment, and qualifies the core response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_ctrl import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core side
  input  logic                   req_i,           // level, held until req_done_o
  input  lsu_size_e              size_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  // bus side
  input  logic                   data_gnt_i,
  input  bus_rsp_t               bus_rsp_i,
  // from load path
  input  logic [`LSU_DATA_W-1:0] ld_rdata_i,
  input  logic                   we_q_i,
  output logic                   data_req_o,
  output logic                   addr_incr_o,     // core should present addr_last + 4
  output logic                   req_done_o,
  output logic                   second_beat_o,
  output logic                   ctrl_update_o,
  output logic                   rdata_update_o,
  output logic [`LSU_DATA_W-1:0] addr_last_o,
  output logic                   busy_o,
  output lsu_rsp_t               rsp_o
);

  ls_fsm_e                state_q, state_d;
  logic                   handle_mis_q, handle_mis_d;  // second beat still to issue
  logic                   lsu_err_q, lsu_err_d;        // first beat came back with err
  logic                   addr_update;
  logic [`LSU_DATA_W-1:0] addr_last_q;
  logic                   split_access;
  logic                   data_err;

  // word not on a boundary, or half crossing into the next word
  assign split_access =
      ((size_i == SIZE_WORD) && (addr_i[`LSU_OFF_W-1:0] != '0)) ||
      ((size_i == SIZE_HALF) && (addr_i[`LSU_OFF_W-1:0] == '1));

  //////////////////////////////////////////////////////////////////////
  // FSM

  always_comb begin
    state_d        = state_q;
    handle_mis_d   = handle_mis_q;
    lsu_err_d      = lsu_err_q;
    data_req_o     = 1'b0;
    addr_incr_o    = 1'b0;
    addr_update    = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;  // fresh access
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            handle_mis_d  = split_access;
            state_d       = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;  // hold first beat
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          handle_mis_d  = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o  = 1'b1;  // second beat goes out right away
        addr_incr_o = 1'b1;
        if (bus_rsp_i.rvalid) begin
          lsu_err_d      = bus_rsp_i.err;
          rdata_update_o = ~we_q_i;
          state_d        = data_gnt_i ? IDLE : WAIT_GNT;
          // keep the failing first address for the trap
          addr_update    = data_gnt_i & ~bus_rsp_i.err;
          handle_mis_d   = ~data_gnt_i;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;  // two beats outstanding now
          state_d      = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        data_req_o  = 1'b1;
        addr_incr_o = handle_mis_q;  // only for a pending second beat
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~lsu_err_q;
          handle_mis_d  = 1'b0;
          state_d       = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_o = 1'b1;  // keeps second address on addr_i for addr_last
        if (bus_rsp_i.rvalid) begin
          lsu_err_d      = bus_rsp_i.err;
          addr_update    = ~bus_rsp_i.err;
          rdata_update_o = ~we_q_i;
          state_d        = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  assign req_done_o = (req_i | (state_q != IDLE)) & (state_d == IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      state_q      <= state_d;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  // last address, for trap value and second-beat increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs and response qualification

  assign second_beat_o = handle_mis_q;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (state_q != IDLE);

  assign data_err = lsu_err_q | bus_rsp_i.err;  // either beat

  // final response only arrives once the FSM is back in IDLE
  assign rsp_o.resp_valid  = bus_rsp_i.rvalid & (state_q == IDLE);
  assign rsp_o.rdata_valid = bus_rsp_i.rvalid & (state_q == IDLE) & ~data_err & ~we_q_i;
  assign rsp_o.load_err    = rsp_o.resp_valid & data_err & ~we_q_i;
  assign rsp_o.store_err   = rsp_o.resp_valid & data_err & we_q_i;
  assign rsp_o.rdata       = ld_rdata_i;

  //////////////////////////////////////////////////////////////////////
  // checks

  a_state_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT,
                    WAIT_RVALID_MIS_GNTS_DONE})
    else $error("lsu_ctrl: illegal state");

  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> !$isunknown(addr_i))
    else $error("lsu_ctrl: unknown address on bus request");

  // core must follow the increment request with the next aligned word
  a_second_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && addr_incr_o) |->
      (addr_i[`LSU_OFF_W-1:0] == '0) &&
      (addr_i[`LSU_DATA_W-1:`LSU_OFF_W] == addr_last_q[`LSU_DATA_W-1:`LSU_OFF_W] + 1'b1))
    else $error("lsu_ctrl: second beat address is not the next word");

endmodule

// File: hw/lsu_top.sv
//////////////////////////////////////////////////////////////////////
// load/store unit top: connects the controller, store path and load
// path to the core request port and the word-aligned data bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core
  input  logic                   req_i,
  input  lsu_req_t               attr_i,
  input  logic [`LSU_DATA_W-1:0] addr_i,
  output logic                   req_done_o,
  output logic                   addr_incr_o,
  output logic [`LSU_DATA_W-1:0] addr_last_o,
  output logic                   busy_o,
  output lsu_rsp_t               rsp_o,
  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  output bus_req_t               bus_req_o,
  input  bus_rsp_t               bus_rsp_i
);

  logic                   second_beat;
  logic                   ctrl_update;
  logic                   rdata_update;
  logic [`LSU_DATA_W-1:0] ld_rdata;
  logic                   we_q;
  logic [`LSU_OFF_W-1:0]  addr_off;

  // on the second beat the core sends the next aligned word, so the
  // access offset still comes from the first address in addr_last
  assign addr_off = second_beat ? addr_last_o[`LSU_OFF_W-1:0]
                                : addr_i[`LSU_OFF_W-1:0];

  lsu_ctrl i_lsu_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .size_i         (attr_i.size),
    .addr_i         (addr_i),
    .data_gnt_i     (data_gnt_i),
    .bus_rsp_i      (bus_rsp_i),
    .ld_rdata_i     (ld_rdata),
    .we_q_i         (we_q),
    .data_req_o     (data_req_o),
    .addr_incr_o    (addr_incr_o),
    .req_done_o     (req_done_o),
    .second_beat_o  (second_beat),
    .ctrl_update_o  (ctrl_update),
    .rdata_update_o (rdata_update),
    .addr_last_o    (addr_last_o),
    .busy_o         (busy_o),
    .rsp_o          (rsp_o)
  );

  lsu_store_align i_lsu_store_align (
    .addr_off_i    (addr_off),
    .size_i        (attr_i.size),
    .second_beat_i (second_beat),
    .wdata_i       (attr_i.wdata),
    .be_o          (bus_req_o.be),
    .wdata_o       (bus_req_o.wdata)
  );

  lsu_load_align i_lsu_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .attr_i         (attr_i),
    .addr_off_i     (addr_off),
    .rdata_i        (bus_rsp_i.rdata),
    .rdata_o        (ld_rdata),
    .we_q_o         (we_q)
  );

  // bus address is the word containing addr_i
  assign bus_req_o.addr = {addr_i[`LSU_DATA_W-1:`LSU_OFF_W], {`LSU_OFF_W{1'b0}}};
  assign bus_req_o.we   = attr_i.we;

endmodule

// File: tb/tb_lsu_top.sv
//////////////////////////////////////////////////////////////////////
// testbench of the load/store unit: runs a table of loads and stores
// against a byte memory model with random grant delays and error beats
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "lsu_params.svh"

module tb_lsu_top import lsu_pkg::*; ();

  localparam int CLK_HALF = 5;

  typedef struct {
    string                  name;
    logic                   we;
    lsu_size_e              size;
    logic                   sext;
    logic [`LSU_DATA_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
    int                     err_beat;  // 0 none, 1 first, 2 second
    logic                   chk;       // compare load with exp_val
    logic [`LSU_DATA_W-1:0] exp_val;
  } test_t;

  logic clk_i, rst_ni, req_i, data_gnt_i;
  lsu_req_t attr_i;
  logic [`LSU_DATA_W-1:0] addr_i, addr_last_o;
  logic req_done_o, addr_incr_o, busy_o, data_req_o;
  lsu_rsp_t rsp_o;
  bus_req_t bus_req_o;
  bus_rsp_t bus_rsp_i, next_rsp;

  logic [7:0] mem [0:255];   // byte memory model
  logic [7:0] lfsr;
  test_t      tests[$];
  int         cycle_limit;
  int         cycles;
  int         gnt_wait;      // cycles left before the bus grants

  lsu_top i_lsu_top (
    .clk_i, .rst_ni, .req_i, .attr_i, .addr_i, .req_done_o, .addr_incr_o,
    .addr_last_o, .busy_o, .rsp_o, .data_req_o, .data_gnt_i, .bus_req_o, .bus_rsp_i
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // run limit in rising edges, armed once the table is built
  initial begin
    cycles = 0;
    while (cycle_limit == 0 || cycles <= cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // x^8+x^6+x^5+x^4+1
  endfunction

  task automatic draw_delay(output int d);
    logic b1, b0;
    lfsr = lfsr_next(lfsr);
    b1   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b0   = lfsr[0];
    d    = int'({b1, b0});  // 0..3 cycles
  endtask

  function automatic int size_bytes(input lsu_size_e s);
    return (s == SIZE_WORD) ? 4 : (s == SIZE_HALF) ? 2 : 1;
  endfunction

  function automatic logic is_split(input test_t t);
    return int'(t.addr[1:0]) + size_bytes(t.size) > 4;  // crosses a word
  endfunction

  // lanes run from the offset upward and the tail lands on the next word
  function automatic bus_req_t exp_beat(input test_t t, input int beat);
    bus_req_t b;
    int o, lane;
    b = '0;
    o = int'(t.addr[1:0]);
    b.addr = {t.addr[`LSU_DATA_W-1:2], 2'b00} + ((beat == 1) ? 32'd4 : 32'd0);
    b.we = t.we;
    for (int k = 0; k < size_bytes(t.size); k++) begin
      lane = o + k;
      if ((lane >= 4) == (beat == 1)) b.be[lane % 4] = 1'b1;
    end
    for (lane = 0; lane < 4; lane++) begin
      b.wdata[8*lane +: 8] = t.wdata[8*((lane + 4 - o) % 4) +: 8];
    end
    return b;
  endfunction

  function automatic logic [`LSU_DATA_W-1:0] model_load(input test_t t);
    logic [`LSU_DATA_W-1:0] v, ba;
    int n;
    v = '0;
    n = size_bytes(t.size);
    for (int k = 0; k < n; k++) begin
      ba = t.addr + k;
      v[8*k +: 8] = mem[ba[7:0]];
    end
    if (t.sext) begin
      for (int k = 8*n; k < 32; k++) v[k] = v[8*n-1];
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_rsp(input string name, input lsu_rsp_t exp, input lsu_rsp_t act,
                           input logic data_chk);
    lsu_rsp_t a;
    a = act;
    if (!data_chk) a.rdata = exp.rdata;  // no load data on a store or an error
    if (a !== exp) begin
      $display("FAIL %s: expected rsp %h, actual rsp %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_beat(input string name, input bus_req_t exp, input bus_req_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected beat %h, actual beat %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "beat mismatch");
    end
  endtask

  task automatic check_addr(input string name, input logic [`LSU_DATA_W-1:0] exp,
                            input logic [`LSU_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected addr_last %h, actual addr_last %h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic add_test(input string name, input logic we, input lsu_size_e size,
                          input logic sext, input logic [31:0] addr, input logic [31:0] wdata,
                          input int err_beat, input logic chk, input logic [31:0] exp_val);
    tests.push_back('{name, we, size, sext, addr, wdata, err_beat, chk, exp_val});
  endtask

  ////////////////////////////////////////////////////////////////////
  // one access cycle by cycle
  // inputs change on the falling edge and outputs are read 1 ns before the rising edge

  task automatic run_test(input test_t t);
    bus_req_t held, beat;
    logic held_v, done, got_rsp, err;
    int beats;
    logic [`LSU_DATA_W-1:0] exp_ld, ba;
    lsu_rsp_t exp_r;
    held = '0;
    held_v = 1'b0;
    done = 1'b0;
    got_rsp = 1'b0;
    beats = 0;
    exp_ld = t.chk ? t.exp_val : model_load(t);
    while (!got_rsp) begin
      @(negedge clk_i);
      req_i      = ~done;
      attr_i     = '{we: t.we, size: t.size, sign_ext: t.sext, wdata: t.wdata};
      addr_i     = addr_incr_o ? {addr_last_o[31:2], 2'b00} + 32'd4 : t.addr;
      bus_rsp_i  = next_rsp;
      next_rsp   = '0;
      data_gnt_i = (gnt_wait == 0);
      #(CLK_HALF - 1);
      if (held_v && (!data_req_o || bus_req_o !== held))
        abort_run($sformatf("%s: beat changed while waiting for grant", t.name));
      held_v = 1'b0;
      if (data_req_o && data_gnt_i) begin
        beat = exp_beat(t, beats);
        check_beat(t.name, beat, bus_req_o);
        beats++;
        err = (beats == t.err_beat);
        for (int l = 0; l < 4; l++) begin
          ba = bus_req_o.addr + l;
          if (t.we && !err && bus_req_o.be[l]) mem[ba[7:0]] = bus_req_o.wdata[8*l +: 8];
          next_rsp.rdata[8*l +: 8] = mem[ba[7:0]];
        end
        next_rsp.rvalid = 1'b1;
        next_rsp.err    = err;
        draw_delay(gnt_wait);
      end else if (data_req_o) begin
        held   = bus_req_o;
        held_v = 1'b1;
        if (gnt_wait > 0) gnt_wait--;
      end
      if (req_done_o) begin
        if (beats != (is_split(t) ? 2 : 1))
          abort_run($sformatf("%s: request done before last beat granted", t.name));
        done = 1'b1;
      end
      if (rsp_o.resp_valid) begin
        got_rsp = 1'b1;
        if (!done) abort_run($sformatf("%s: response came before request done", t.name));
        if (busy_o) abort_run($sformatf("%s: unit still busy at response", t.name));
        if (beats != (is_split(t) ? 2 : 1))
          abort_run($sformatf("%s: wrong number of bus beats (%0d)", t.name, beats));
        err = (t.err_beat != 0);
        exp_r = '{rdata: exp_ld, rdata_valid: ~t.we & ~err, resp_valid: 1'b1,
                  load_err: err & ~t.we, store_err: err & t.we};
        check_rsp(t.name, exp_r, rsp_o, !t.we && !err);
        if (t.err_beat == 1 || !is_split(t)) check_addr(t.name, t.addr, addr_last_o);
        else check_addr(t.name, {t.addr[31:2], 2'b00} + 32'd4, addr_last_o);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // test table and main sequence

  initial begin
    rst_ni = 1'b0;
    req_i = 1'b0;
    attr_i = '0;
    addr_i = '0;
    data_gnt_i = 1'b0;
    bus_rsp_i = '0;
    next_rsp = '0;
    cycle_limit = 0;
    lfsr = 8'd69;
    for (int a = 0; a < 256; a++) mem[a] = 8'(a * 37 + 11);  // each address its own byte
    draw_delay(gnt_wait);

    add_test("st_word_al",  1, SIZE_WORD, 0, 32'h10, 32'hDEADBEEF, 0, 0, 0);
    add_test("ld_word_al",  0, SIZE_WORD, 0, 32'h10, 0, 0, 1, 32'hDEADBEEF);
    add_test("st_sign_src", 1, SIZE_WORD, 0, 32'h20, 32'h80817F01, 0, 0, 0);
    for (int o = 0; o < 4; o++) begin
      add_test($sformatf("lbu_off%0d", o), 0, SIZE_BYTE, 0, 32'h20 + o, 0, 0, 0, 0);
      add_test($sformatf("lb_off%0d", o),  0, SIZE_BYTE, 1, 32'h20 + o, 0, 0, 0, 0);
      add_test($sformatf("lhu_off%0d", o), 0, SIZE_HALF, 0, 32'h20 + o, 0, 0, 0, 0);
      add_test($sformatf("lh_off%0d", o),  0, SIZE_HALF, 1, 32'h20 + o, 0, 0, 0, 0);
    end
    add_test("st_word_off1", 1, SIZE_WORD, 0, 32'h31, 32'h11223344, 0, 0, 0);
    add_test("ld_word_off1", 0, SIZE_WORD, 0, 32'h31, 0, 0, 1, 32'h11223344);
    add_test("st_word_off2", 1, SIZE_WORD, 0, 32'h42, 32'h55667788, 0, 0, 0);
    add_test("ld_word_off2", 0, SIZE_WORD, 0, 32'h42, 0, 0, 1, 32'h55667788);
    add_test("st_word_off3", 1, SIZE_WORD, 0, 32'h53, 32'h99AABBCC, 0, 0, 0);
    add_test("ld_word_off3", 0, SIZE_WORD, 0, 32'h53, 0, 0, 1, 32'h99AABBCC);
    add_test("st_half_off3", 1, SIZE_HALF, 0, 32'h63, 32'h1234BEEF, 0, 0, 0);
    add_test("lhu_half_off3", 0, SIZE_HALF, 0, 32'h63, 0, 0, 1, 32'h0000BEEF);
    add_test("st_half_off2", 1, SIZE_HALF, 0, 32'h62, 32'h0000C0DE, 0, 0, 0);
    add_test("lh_half_off2", 0, SIZE_HALF, 1, 32'h62, 0, 0, 1, 32'hFFFFC0DE);
    add_test("ld_err_b1",     0, SIZE_WORD, 0, 32'h70, 0, 1, 0, 0);
    add_test("ld_err_mis_b1", 0, SIZE_WORD, 0, 32'h71, 0, 1, 0, 0);
    add_test("ld_err_mis_b2", 0, SIZE_WORD, 0, 32'h72, 0, 2, 0, 0);
    add_test("st_err_mis_b2", 1, SIZE_WORD, 0, 32'h75, 32'hCAFEF00D, 2, 0, 0);
    add_test("st_err_b1",     1, SIZE_BYTE, 0, 32'h80, 32'h000000A5, 1, 0, 0);
    add_test("ld_after_err",  0, SIZE_WORD, 0, 32'h10, 0, 0, 1, 32'hDEADBEEF);

    cycle_limit = 40 * tests.size() + 20;  // plus reset and settle
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    foreach (tests[i]) run_test(tests[i]);
    $display("all %0d table entries checked", tests.size());
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: lsu_top.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_align.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
tb/tb_lsu_top.sv

// File: Makefile
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') hw/lsu_params.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
